//--- source/dictionary_pkg.sv
package dictionary_pkg;

    // Column geometry
    localparam int NUM_BANKS   = 4;
    localparam int BANK_BITS   = 2;
    localparam int NUM_ENTRIES = 256;
    localparam int ROW_BITS    = $clog2(NUM_ENTRIES);
    localparam int BANK_DEPTH  = NUM_ENTRIES / NUM_BANKS;  // Rows per bank

    // Lookup side
    localparam int NUM_LANES      = 2;
    localparam int MAX_IN_TRANSIT = 16;
    localparam int SERIAL_BITS    = 4;   // log2 of MAX_IN_TRANSIT

    typedef logic [31:0]                        value_t;
    typedef logic [ROW_BITS-1:0]                row_id_t;
    typedef logic [ROW_BITS-BANK_BITS-1:0]      bank_addr_t;
    typedef logic [SERIAL_BITS-1:0]             serial_t;
    typedef logic [NUM_LANES*ROW_BITS-1:0]      id_beat_t;    // Lane 0 in the low byte
    typedef logic [$clog2(MAX_IN_TRANSIT+1)-1:0] credit_t;

    // Dispatcher FSM
    typedef enum logic {
        ISSUE_BOTH,     // Idle or issuing a full beat
        ISSUE_SECOND    // Lane 1 of a same-bank pair still pending
    } dispatch_state_t;

endpackage

//--- source/bank_lookup_if.sv
`timescale 1ns/1ns

interface bank_lookup_if import dictionary_pkg::*; ();

    // Request from the dispatcher, taken whenever req_valid is high
    logic       req_valid;
    bank_addr_t req_addr;
    serial_t    req_serial;

    // Tagged response, exactly one cycle after the request
    logic       rsp_valid;
    value_t     rsp_value;
    serial_t    rsp_serial;

    modport dispatch (
        output req_valid,
        output req_addr,
        output req_serial
    );

    modport bank (
        input  req_valid,
        input  req_addr,
        input  req_serial,
        output rsp_valid,
        output rsp_value,
        output rsp_serial
    );

    modport collect (
        input rsp_valid,
        input rsp_value,
        input rsp_serial
    );

endinterface

//--- source/value_distributor.sv
`timescale 1ns/1ns

module value_distributor import dictionary_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 value_valid_i,
    output logic                 value_ready_o,
    input  value_t               value_data_i,
    input  logic                 value_last_i,
    output logic [NUM_BANKS-1:0] wr_en_o,
    output bank_addr_t           wr_addr_o,
    output value_t               wr_data_o,
    output logic                 load_done_o
);

    row_id_t row_cnt_q;     // Row index of the next value
    logic    load_done_q;
    logic    accept;

    assign value_ready_o = !load_done_q;
    assign accept        = value_valid_i && value_ready_o;

    // Low bits pick the bank, the rest is the row inside it
    always_comb begin
        wr_en_o = '0;
        wr_en_o[row_cnt_q[BANK_BITS-1:0]] = accept;
    end

    assign wr_addr_o   = row_cnt_q[ROW_BITS-1:BANK_BITS];
    assign wr_data_o   = value_data_i;
    assign load_done_o = load_done_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            row_cnt_q   <= '0;
            load_done_q <= 1'b0;
        end else if (accept) begin
            row_cnt_q <= row_cnt_q + row_id_t'(1);
            if (value_last_i) begin
                load_done_q <= 1'b1;   // Loading ends for good
            end
        end
    end

    // The last row of the column must carry the last flag
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        accept && row_cnt_q == row_id_t'(NUM_ENTRIES - 1) |-> value_last_i
    );

endmodule

//--- source/dictionary_bank.sv
`timescale 1ns/1ns

module dictionary_bank import dictionary_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        wr_en_i,
    input  bank_addr_t  wr_addr_i,
    input  value_t      wr_data_i,
    bank_lookup_if.bank lookup
);

    value_t  mem [BANK_DEPTH];

    value_t  rd_value_q;
    serial_t rd_serial_q;
    logic    rd_valid_q;

    // Load port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read, serial rides alongside
    always_ff @(posedge clk) begin
        if (lookup.req_valid) begin
            rd_value_q <= mem[lookup.req_addr];
        end
        rd_serial_q <= lookup.req_serial;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= lookup.req_valid;
        end
    end

    assign lookup.rsp_valid  = rd_valid_q;
    assign lookup.rsp_value  = rd_value_q;
    assign lookup.rsp_serial = rd_serial_q;

    // Load and lookup phases never overlap
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(wr_en_i && lookup.req_valid)
    );

endmodule

//--- source/id_dispatcher.sv
`timescale 1ns/1ns

module id_dispatcher import dictionary_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            load_done_i,
    input  logic            id_valid_i,
    output logic            id_ready_o,
    input  id_beat_t        id_data_i,
    input  logic            credit_return_i,
    bank_lookup_if.dispatch lookup [NUM_BANKS]
);

    dispatch_state_t state_q;
    credit_t         credits_q;      // Free slots in the reorder buffer
    serial_t         serial_q;       // Serial for the next lane 0
    row_id_t         held_id_q;      // Lane 1 of a split beat
    serial_t         held_serial_q;

    row_id_t              lane_id   [NUM_LANES];
    logic [BANK_BITS-1:0] lane_bank [NUM_LANES];
    logic                 same_bank;
    logic                 accept;

    logic [NUM_BANKS-1:0] req_valid_d;
    logic [NUM_BANKS-1:0] req_valid_q;
    bank_addr_t           req_addr_d   [NUM_BANKS];
    bank_addr_t           req_addr_q   [NUM_BANKS];
    serial_t              req_serial_d [NUM_BANKS];
    serial_t              req_serial_q [NUM_BANKS];

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        assign lane_id[l]   = id_data_i[l*ROW_BITS +: ROW_BITS];
        assign lane_bank[l] = lane_id[l][BANK_BITS-1:0];
    end

    assign same_bank  = lane_bank[0] == lane_bank[1];
    assign id_ready_o = load_done_i && state_q == ISSUE_BOTH &&
                        credits_q >= credit_t'(NUM_LANES);
    assign accept     = id_valid_i && id_ready_o;

    // Route each id to the bank named by its low bits
    always_comb begin
        req_valid_d  = '0;
        req_addr_d   = req_addr_q;
        req_serial_d = req_serial_q;
        if (state_q == ISSUE_SECOND) begin
            req_valid_d[held_id_q[BANK_BITS-1:0]]  = 1'b1;
            req_addr_d[held_id_q[BANK_BITS-1:0]]   = held_id_q[ROW_BITS-1:BANK_BITS];
            req_serial_d[held_id_q[BANK_BITS-1:0]] = held_serial_q;
        end else if (accept) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (l == 0 || !same_bank) begin   // Same-bank lane 1 waits a cycle
                    req_valid_d[lane_bank[l]]  = 1'b1;
                    req_addr_d[lane_bank[l]]   = lane_id[l][ROW_BITS-1:BANK_BITS];
                    req_serial_d[lane_bank[l]] = serial_q + serial_t'(l);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= ISSUE_BOTH;
            credits_q   <= credit_t'(MAX_IN_TRANSIT);
            serial_q    <= '0;
            req_valid_q <= '0;
        end else begin
            req_valid_q <= req_valid_d;
            case (state_q)
                ISSUE_BOTH:   if (accept && same_bank) state_q <= ISSUE_SECOND;
                ISSUE_SECOND: state_q <= ISSUE_BOTH;
                default:      state_q <= ISSUE_BOTH;
            endcase
            if (accept) begin
                serial_q <= serial_q + serial_t'(NUM_LANES);
            end
            case ({accept, credit_return_i})
                2'b10:   credits_q <= credits_q - credit_t'(NUM_LANES);
                2'b01:   credits_q <= credits_q + credit_t'(1);
                2'b11:   credits_q <= credits_q - credit_t'(NUM_LANES - 1);
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        req_addr_q   <= req_addr_d;
        req_serial_q <= req_serial_d;
        if (accept) begin
            held_id_q     <= lane_id[1];
            held_serial_q <= serial_q + serial_t'(1);
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign lookup[b].req_valid  = req_valid_q[b];
        assign lookup[b].req_addr   = req_addr_q[b];
        assign lookup[b].req_serial = req_serial_q[b];
    end

    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        credits_q <= credit_t'(MAX_IN_TRANSIT)
    );

    // A returned credit needs a lookup in flight
    a_credit_min: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        credit_return_i |-> credits_q < credit_t'(MAX_IN_TRANSIT)
    );

    // Lane 1 never takes the bank request of lane 0
    a_one_req_per_bank: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        accept |=> req_valid_q[$past(id_data_i[BANK_BITS-1:0])] &&
                   req_serial_q[$past(id_data_i[BANK_BITS-1:0])] == $past(serial_q)
    );

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer import dictionary_pkg::*; (
    input  logic           clk,
    input  logic           rst_n_i,
    bank_lookup_if.collect lookup [NUM_BANKS],
    output logic           out_valid_o,
    input  logic           out_ready_i,
    output value_t         out_value_o,
    output logic           credit_return_o
);

    value_t                    slot_mem [MAX_IN_TRANSIT];
    logic [MAX_IN_TRANSIT-1:0] filled_q;
    serial_t                   head_q;    // Oldest lookup not yet delivered
    logic                      handshake;

    logic    rsp_valid  [NUM_BANKS];
    value_t  rsp_value  [NUM_BANKS];
    serial_t rsp_serial [NUM_BANKS];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_collect
        assign rsp_valid[b]  = lookup[b].rsp_valid;
        assign rsp_value[b]  = lookup[b].rsp_value;
        assign rsp_serial[b] = lookup[b].rsp_serial;

        // Credits keep every slot free until its response arrives
        a_slot_free: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            rsp_valid[b] |-> !filled_q[rsp_serial[b]]
        );
    end

    assign out_valid_o     = filled_q[head_q];
    assign out_value_o     = slot_mem[head_q];
    assign handshake       = out_valid_o && out_ready_i;
    assign credit_return_o = handshake;   // One slot freed per output

    // Up to one response per bank each cycle
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (rsp_valid[b]) begin
                slot_mem[rsp_serial[b]] <= rsp_value[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            filled_q <= '0;
            head_q   <= '0;
        end else begin
            if (handshake) begin
                filled_q[head_q] <= 1'b0;
                head_q           <= head_q + serial_t'(1);
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (rsp_valid[b]) begin
                    filled_q[rsp_serial[b]] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/dictionary.sv
`timescale 1ns/1ns

module dictionary import dictionary_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,

    // Column load
    input  logic     value_valid_i,
    output logic     value_ready_o,
    input  value_t   value_data_i,
    input  logic     value_last_i,

    // Row id beats
    input  logic     id_valid_i,
    output logic     id_ready_o,
    input  id_beat_t id_data_i,

    // Materialized values, in request order
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output value_t   out_value_o
);

    logic [NUM_BANKS-1:0] wr_en;
    bank_addr_t           wr_addr;
    value_t               wr_data;
    logic                 load_done;
    logic                 credit_return;

    bank_lookup_if lookup_if [NUM_BANKS] ();

    value_distributor value_distributor_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .value_valid_i (value_valid_i),
        .value_ready_o (value_ready_o),
        .value_data_i  (value_data_i),
        .value_last_i  (value_last_i),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data),
        .load_done_o   (load_done)
    );

    // Write address and data are shared, enables pick the bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dictionary_bank dictionary_bank_i (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .wr_en_i   (wr_en[b]),
            .wr_addr_i (wr_addr),
            .wr_data_i (wr_data),
            .lookup    (lookup_if[b])
        );
    end

    id_dispatcher id_dispatcher_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .load_done_i     (load_done),
        .id_valid_i      (id_valid_i),
        .id_ready_o      (id_ready_o),
        .id_data_i       (id_data_i),
        .credit_return_i (credit_return),
        .lookup          (lookup_if)
    );

    reorder_buffer reorder_buffer_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .lookup          (lookup_if),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_value_o     (out_value_o),
        .credit_return_o (credit_return)
    );

endmodule

//--- tests/dictionary_tb.sv
`timescale 1ns/1ns

module dictionary_tb import dictionary_pkg::*; ();

    localparam int NUM_TESTS    = 5;
    localparam int PAT_CONSEC   = 0;
    localparam int PAT_SAME     = 1;
    localparam int PAT_RANDOM   = 2;
    localparam int RDY_ALWAYS   = 0;
    localparam int RDY_STALL    = 1;
    localparam int RDY_LOW      = 2;
    localparam int QUIET_CYCLES = 30;   // Idle cycles that count as a settled id_ready_o

    // Stimulus table, one column per field
    string test_name  [NUM_TESTS] = '{"spread_banks", "same_bank", "random_stalls",
                                      "short_column", "held_low"};
    int    load_len   [NUM_TESTS] = '{64, 100, 256, 5, 200};   // Same-bank row needs a multiple of 4
    int    pattern    [NUM_TESTS] = '{PAT_CONSEC, PAT_SAME, PAT_RANDOM, PAT_RANDOM, PAT_RANDOM};
    int    ready_mode [NUM_TESTS] = '{RDY_ALWAYS, RDY_ALWAYS, RDY_STALL, RDY_ALWAYS, RDY_LOW};
    int    num_beats  [NUM_TESTS] = '{16, 12, 40, 6, 12};

    logic     clk;
    logic     rst_n_i;
    logic     value_valid_i;
    logic     value_ready_o;
    value_t   value_data_i;
    logic     value_last_i;
    logic     id_valid_i;
    logic     id_ready_o;
    id_beat_t id_data_i;
    logic     out_valid_o;
    logic     out_ready_i;
    value_t   out_value_o;

    value_t   column [NUM_ENTRIES];   // Reference copy of the loaded column
    value_t   expected_q [$];
    id_beat_t beat_list [$];
    integer   seed = 88531;
    int       errors;
    int       checks;
    int       watchdog_cycles;

    dictionary dictionary_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .value_valid_i (value_valid_i),
        .value_ready_o (value_ready_o),
        .value_data_i  (value_data_i),
        .value_last_i  (value_last_i),
        .id_valid_i    (id_valid_i),
        .id_ready_o    (id_ready_o),
        .id_data_i     (id_data_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_value_o   (out_value_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input value_t exp, input value_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input credit_t exp, input credit_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic apply_reset();
        rst_n_i       <= 1'b0;
        value_valid_i <= 1'b0;
        value_last_i  <= 1'b0;
        id_valid_i    <= 1'b0;
        out_ready_i   <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    function automatic id_beat_t make_beat(input int t, input int b);
        int id0;
        int id1;
        case (pattern[t])
            PAT_CONSEC: begin
                id0 = (2 * b) % load_len[t];
                id1 = (2 * b + 1) % load_len[t];
            end
            PAT_SAME: begin
                id0 = $unsigned($random(seed)) % load_len[t];
                id1 = (id0 + NUM_BANKS) % load_len[t];   // Keeps the bank bits
            end
            default: begin
                id0 = $unsigned($random(seed)) % load_len[t];
                id1 = $unsigned($random(seed)) % load_len[t];
            end
        endcase
        return {row_id_t'(id1), row_id_t'(id0)};
    endfunction

    task automatic load_column(input int t);
        int row;
        row = 0;
        for (int i = 0; i < load_len[t]; i++) begin
            column[i] = $random(seed);
        end
        value_valid_i <= 1'b1;
        value_data_i  <= column[0];
        value_last_i  <= load_len[t] == 1;
        while (row < load_len[t]) begin
            @(posedge clk);
            check_level({test_name[t], " id_ready_o during load"}, 1'b0, id_ready_o);
            if (value_valid_i && value_ready_o) begin
                row++;
            end
            value_valid_i <= row < load_len[t];
            value_data_i  <= column[row % NUM_ENTRIES];
            value_last_i  <= row == load_len[t] - 1;
        end
    endtask

    task automatic lookup_phase(input int t);
        int     sent;
        int     outs;
        int     quiet;
        int     target;
        logic   released;
        value_t exp;
        sent     = 0;
        outs     = 0;
        quiet    = 0;
        target   = num_beats[t];
        released = ready_mode[t] != RDY_LOW;
        id_valid_i  <= 1'b1;
        id_data_i   <= beat_list[0];
        out_ready_i <= released;
        while (sent < target || outs < NUM_LANES * sent) begin
            @(posedge clk);
            check_level({test_name[t], " value_ready_o after load"}, 1'b0, value_ready_o);
            if (id_valid_i && id_ready_o) begin
                expected_q.push_back(column[beat_list[sent][ROW_BITS-1:0]]);   // Lane 0 first
                expected_q.push_back(column[beat_list[sent][2*ROW_BITS-1:ROW_BITS]]);
                sent++;
                quiet = 0;
            end else begin
                quiet++;
            end
            if (out_valid_o && out_ready_i) begin
                outs++;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("%s: the DUT delivered a value with no lookup pending", test_name[t]);
                end else begin
                    exp = expected_q.pop_front();
                    check_value({test_name[t], " out_value_o"}, exp, out_value_o);
                end
            end
            // Output held low until the credits are used up
            if (!released && quiet >= QUIET_CYCLES) begin
                check_count({test_name[t], " beats accepted"},
                            credit_t'(MAX_IN_TRANSIT / NUM_LANES), credit_t'(sent));
                released = 1'b1;
                target   = sent;
            end
            id_valid_i  <= sent < target;
            id_data_i   <= beat_list[sent < target ? sent : 0];
            out_ready_i <= released && (ready_mode[t] != RDY_STALL || ($random(seed) & 3) != 0);
        end
        id_valid_i  <= 1'b0;
        out_ready_i <= 1'b1;
    endtask

    task automatic run_test(input int t);
        int errors_before;
        errors_before = errors;
        apply_reset();
        @(posedge clk);
        check_level({test_name[t], " value_ready_o after reset"}, 1'b1, value_ready_o);
        check_level({test_name[t], " id_ready_o after reset"}, 1'b0, id_ready_o);
        check_level({test_name[t], " out_valid_o after reset"}, 1'b0, out_valid_o);
        load_column(t);
        beat_list.delete();
        expected_q.delete();
        for (int b = 0; b < num_beats[t]; b++) begin
            beat_list.push_back(make_beat(t, b));
        end
        lookup_phase(t);
        repeat (20) begin
            @(posedge clk);
            check_level({test_name[t], " out_valid_o when drained"}, 1'b0, out_valid_o);
        end
        check_level({test_name[t], " id_ready_o when drained"}, 1'b1, id_ready_o);
        $display("%s finished with %0d errors", test_name[t], errors - errors_before);
    endtask

    // Watchdog
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int total_beats;
        rst_n_i       = 1'b0;
        value_valid_i = 1'b0;
        value_data_i  = '0;
        value_last_i  = 1'b0;
        id_valid_i    = 1'b0;
        id_data_i     = '0;
        out_ready_i   = 1'b0;
        errors        = 0;
        checks        = 0;
        total_beats   = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_beats += num_beats[i];
        end
        watchdog_cycles = 100 * NUM_TESTS + 40 * total_beats;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- dictionary.f
source/dictionary_pkg.sv
source/bank_lookup_if.sv
source/value_distributor.sv
source/dictionary_bank.sv
source/id_dispatcher.sv
source/reorder_buffer.sv
source/dictionary.sv
tests/dictionary_tb.sv
